//--- Makefile
# Verilator build and run of the chase engine testbench
SRCS := $(shell cat enemyEngine.f)

obj_dir/VenemyEngineTb: enemyEngine.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module enemyEngineTb -f enemyEngine.f

run: obj_dir/VenemyEngineTb
	@out="$$(./obj_dir/VenemyEngineTb)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- enemyEngine.f
rtl/gamePkg.sv
rtl/enemyPkg.sv
rtl/enemyTableIf.sv
rtl/enemyChaser.sv
rtl/enemyStateTable.sv
rtl/spriteRenderer.sv
rtl/enemyEngine.sv
verification/enemyEngine_assertions.sv
verification/enemyChecker.sv
verification/enemyEngineTb.sv

//--- rtl/enemyChaser.sv
// Per-frame enemy update. Each frameTick walks the table once:
// one cycle to fetch a record, one cycle to write the moved record
// back. updateDone pulses the cycle after the last write.
// Ticks that arrive mid-update are dropped.
module enemyChaser import gamePkg::*, enemyPkg::*; #(
    parameter int NumEnemies = 3
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  frameTick,
    input  coordT                 playerX,
    input  coordT                 playerY,
    input  logic [NumEnemies-1:0] alive,
    enemyTableIf.chaser           tbl,
    output logic                  updateDone
);

    chaseStateT state;
    logic [1:0] enemyIdx;
    logic       lastEnemy;
    enemyRecT   curRec;     // Record fetched in ChaseRead
    enemyRecT   nextRec;

    // Edges of the enemy sprite and the player window, 10 bits to avoid wrap
    logic [9:0] xRight;
    logic [9:0] yBottom;
    logic [9:0] playerXEnd;
    logic [9:0] playerYEnd;

    dirT        moveDir;
    logic       wantMove;
    logic       blocked;
    logic       moved;

    assign lastEnemy = (enemyIdx == 2'(NumEnemies - 1));

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state      <= ChaseIdle;
            enemyIdx   <= 2'd0;
            updateDone <= 1'b0;
        end else begin
            updateDone <= 1'b0;
            case (state)
                ChaseIdle: begin
                    if (frameTick) begin
                        enemyIdx <= 2'd0;
                        state    <= ChaseRead;
                    end
                end
                ChaseRead: state <= ChaseWrite;
                ChaseWrite: begin
                    if (lastEnemy) begin
                        state      <= ChaseIdle;
                        updateDone <= 1'b1;  // Table is fully updated now
                    end else begin
                        enemyIdx <= enemyIdx + 2'd1;
                        state    <= ChaseRead;
                    end
                end
                default: state <= ChaseIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == ChaseRead)
            curRec <= tbl.rdRec;
    end

    assign xRight     = 10'(curRec.xPos) + 10'(EnemyWidth);
    assign yBottom    = 10'(curRec.yPos) + 10'(EnemyHeight);
    assign playerXEnd = 10'(playerX) + 10'(PlayerWidth);
    assign playerYEnd = 10'(playerY) + 10'(PlayerHeight);

    // Pick one axis toward the player: right, left, down, up
    always_comb begin
        wantMove = 1'b1;
        moveDir  = curRec.dir;
        if (xRight < 10'(playerX))
            moveDir = DirRight;
        else if (10'(curRec.xPos) > playerXEnd)
            moveDir = DirLeft;
        else if (yBottom < 10'(playerY))
            moveDir = DirDown;
        else if (10'(curRec.yPos) > playerYEnd)
            moveDir = DirUp;
        else
            wantMove = 1'b0;  // Overlapping the player window

        case (moveDir)
            DirRight: blocked = (xRight >= 10'(XMax));
            DirLeft:  blocked = (curRec.xPos <= XMin);
            DirDown:  blocked = (yBottom >= 10'(YMax));
            default:  blocked = (curRec.yPos <= YMin);
        endcase
    end

    assign moved = wantMove && !blocked;

    always_comb begin
        nextRec             = curRec;
        nextRec.attackReady = 1'b0;  // Dead enemies only lose attackReady
        if (alive[enemyIdx]) begin
            nextRec.dir         = moveDir;
            nextRec.attackReady = !moved;
            if (moved) begin
                nextRec.stepCount = curRec.stepCount + 2'd1;
                case (moveDir)
                    DirRight: nextRec.xPos = curRec.xPos + StepSize;
                    DirLeft:  nextRec.xPos = curRec.xPos - StepSize;
                    DirDown:  nextRec.yPos = curRec.yPos + StepSize;
                    default:  nextRec.yPos = curRec.yPos - StepSize;
                endcase
            end
        end
    end

    assign tbl.rdIdx = enemyIdx;
    assign tbl.wrIdx = enemyIdx;
    assign tbl.wrEn  = (state == ChaseWrite);
    assign tbl.wrRec = nextRec;

endmodule

//--- rtl/enemyEngine.sv
// Top level of the multi-enemy chase engine. A frame tick triggers
// one pass of the chaser over the state table; the renderer answers
// per-pixel queries in parallel. Enemy positions come out flattened,
// enemy i at bits [9*i +: 9].
module enemyEngine import gamePkg::*; #(
    parameter int NumEnemies = 3  // 1 to 4
) (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    frameTick,
    input  coordT                   playerX,
    input  coordT                   playerY,
    input  logic [NumEnemies-1:0]   alive,
    input  coordT                   pixelX,
    input  coordT                   pixelY,
    output logic                    isEnemy,
    output addrT                    spriteAddr,
    output logic [NumEnemies-1:0]   attackReady,
    output logic [NumEnemies*9-1:0] enemyXPos,
    output logic [NumEnemies*9-1:0] enemyYPos,
    output logic                    updateDone
);

    coordT xPosArr [NumEnemies];
    coordT yPosArr [NumEnemies];

    enemyTableIf #(.NumEnemies(NumEnemies)) tblIf ();

    enemyChaser #(.NumEnemies(NumEnemies)) chaser (
        .Clk        (Clk),
        .rstN       (rstN),
        .frameTick  (frameTick),
        .playerX    (playerX),
        .playerY    (playerY),
        .alive      (alive),
        .tbl        (tblIf.chaser),
        .updateDone (updateDone)
    );

    enemyStateTable #(.NumEnemies(NumEnemies)) stateTable (
        .Clk         (Clk),
        .rstN        (rstN),
        .tbl         (tblIf.store),
        .alive       (alive),
        .attackReady (attackReady),
        .enemyXPos   (xPosArr),
        .enemyYPos   (yPosArr)
    );

    spriteRenderer #(.NumEnemies(NumEnemies)) renderer (
        .Clk        (Clk),
        .rstN       (rstN),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .alive      (alive),
        .recs       (tblIf.view),
        .isEnemy    (isEnemy),
        .spriteAddr (spriteAddr)
    );

    // Pack per-enemy positions onto the flat output buses
    always_comb begin
        for (int i = 0; i < NumEnemies; i++) begin
            enemyXPos[i*9 +: 9] = xPosArr[i];
            enemyYPos[i*9 +: 9] = yPosArr[i];
        end
    end

endmodule

//--- rtl/enemyPkg.sv
// Enemy record layout, chaser FSM states and spawn positions.
// Used by the chaser, the state table and the renderer.
package enemyPkg;
    import gamePkg::*;

    // Spawn centres are spaced on a diagonal
    localparam int SpawnXPitch = 70;
    localparam int SpawnYPitch = 40;

    // One enemy, 23 bits, attackReady on top
    typedef struct packed {
        logic       attackReady;
        coordT      xPos;       // Top-left corner
        coordT      yPos;
        dirT        dir;        // Facing, picks the sprite row
        logic [1:0] stepCount;  // Walk phase
    } enemyRecT;

    typedef enum logic [1:0] {
        ChaseIdle,
        ChaseRead,
        ChaseWrite
    } chaseStateT;

    // Spawn record for enemy i, sprite centred on the spawn point
    function automatic enemyRecT resetRec(int unsigned i);
        enemyRecT r;
        r.attackReady = 1'b0;
        r.xPos        = coordT'(SpawnXPitch * (i + 1) - int'(EnemyWidth >> 1));
        r.yPos        = coordT'(SpawnYPitch * (i + 1) - int'(EnemyHeight >> 1));
        r.dir         = DirDown;
        r.stepCount   = 2'd0;
        return r;
    endfunction

endpackage

//--- rtl/enemyStateTable.sv
// Register array holding every enemy record. One combinational read
// port and one write port serve the chaser; all records are exposed
// to the renderer and to the position and attack-ready outputs.
module enemyStateTable import gamePkg::*, enemyPkg::*; #(
    parameter int NumEnemies = 3
) (
    input  logic                  Clk,
    input  logic                  rstN,
    enemyTableIf.store            tbl,
    input  logic [NumEnemies-1:0] alive,
    output logic [NumEnemies-1:0] attackReady,
    output coordT                 enemyXPos [NumEnemies],
    output coordT                 enemyYPos [NumEnemies]
);

    enemyRecT recs [NumEnemies];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumEnemies; i++)
                recs[i] <= resetRec(i);  // Back to spawn points
        end else if (tbl.wrEn) begin
            recs[tbl.wrIdx] <= tbl.wrRec;
        end
    end

    assign tbl.rdRec   = recs[tbl.rdIdx];
    assign tbl.allRecs = recs;

    always_comb begin
        for (int i = 0; i < NumEnemies; i++) begin
            enemyXPos[i]   = recs[i].xPos;
            enemyYPos[i]   = recs[i].yPos;
            // A death drops attackReady right away, not at the next frame
            attackReady[i] = recs[i].attackReady && alive[i];
        end
    end

endmodule

//--- rtl/enemyTableIf.sv
// Connects the enemy state table to its writer (chaser) and its
// readers. The chaser reads one record at a time through rdIdx/rdRec
// and writes back with a one-cycle wrEn strobe; the renderer sees
// every record at once through allRecs.
interface enemyTableIf import enemyPkg::*; #(
    parameter int NumEnemies = 3
);

    logic [1:0] rdIdx;
    enemyRecT   rdRec;      // Combinational from rdIdx
    logic       wrEn;       // One-cycle write strobe
    logic [1:0] wrIdx;
    enemyRecT   wrRec;
    enemyRecT   allRecs [NumEnemies];

    // Producer side
    modport chaser (
        output rdIdx, wrEn, wrIdx, wrRec,
        input  rdRec
    );

    // Storage side
    modport store (
        input  rdIdx, wrEn, wrIdx, wrRec,
        output rdRec, allRecs
    );

    // Read-only view of all records
    modport view (
        input allRecs
    );

endinterface

//--- rtl/gamePkg.sv
// Screen, playfield and sprite geometry shared by the chase engine.
// Import into any module that handles coordinates, directions or
// sprite ROM addresses.
package gamePkg;

    typedef logic [8:0]  coordT;  // Screen coordinate, 320x240 fits in 9 bits
    typedef logic [12:0] addrT;   // Sprite ROM address

    // Facing direction, also selects the sprite row in ROM
    typedef enum logic [1:0] {
        DirDown  = 2'd0,
        DirLeft  = 2'd1,
        DirUp    = 2'd2,
        DirRight = 2'd3
    } dirT;

    localparam coordT EnemyWidth   = 9'd26;
    localparam coordT EnemyHeight  = 9'd26;
    localparam coordT PlayerWidth  = 9'd18;
    localparam coordT PlayerHeight = 9'd20;

    // Playfield limits for the enemy top-left corner
    localparam coordT XMin = 9'd0;
    localparam coordT XMax = 9'd319;
    localparam coordT YMin = 9'd52;
    localparam coordT YMax = 9'd205;

    localparam coordT StepSize  = 9'd1;    // Pixels per frame
    localparam addrT  FrameSize = 13'd676; // 26 x 26 pixels per sprite frame

endpackage

//--- rtl/spriteRenderer.sv
// Per-pixel enemy lookup for the video path. Tests the scan pixel
// against every living enemy and returns the hit flag and the sprite
// ROM address, one cycle later. The lowest enemy index wins overlaps.
module spriteRenderer import gamePkg::*, enemyPkg::*; #(
    parameter int NumEnemies = 3
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  coordT                 pixelX,
    input  coordT                 pixelY,
    input  logic [NumEnemies-1:0] alive,
    enemyTableIf.view             recs,
    output logic                  isEnemy,
    output addrT                  spriteAddr
);

    logic hitNext;
    addrT addrNext;

    // True when the pixel lies inside the enemy's 26x26 box
    function automatic logic insideSprite(coordT px, coordT py, enemyRecT r);
        logic inX;
        logic inY;
        inX = (px >= r.xPos) && (10'(px) < 10'(r.xPos) + 10'(EnemyWidth));
        inY = (py >= r.yPos) && (10'(py) < 10'(r.yPos) + 10'(EnemyHeight));
        return inX && inY;
    endfunction

    // Frame index: 3 frames per direction, stand pose on even steps
    function automatic addrT spriteOffset(coordT px, coordT py, enemyRecT r);
        addrT dx;
        addrT dy;
        addrT frame;
        dx    = addrT'(coordT'(px - r.xPos));
        dy    = addrT'(coordT'(py - r.yPos));
        frame = addrT'(3 * r.dir);
        if (r.stepCount[0])
            frame = frame + 13'd1 + addrT'(r.stepCount[1]);
        return dx + dy * addrT'(EnemyWidth) + frame * FrameSize;
    endfunction

    // Walk from the top index down so index 0 has the final say
    always_comb begin
        hitNext  = 1'b0;
        addrNext = '0;
        for (int i = NumEnemies - 1; i >= 0; i--) begin
            if (alive[i] && insideSprite(pixelX, pixelY, recs.allRecs[i])) begin
                hitNext  = 1'b1;
                addrNext = spriteOffset(pixelX, pixelY, recs.allRecs[i]);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN)
            isEnemy <= 1'b0;
        else
            isEnemy <= hitNext;
    end

    always_ff @(posedge Clk) begin
        spriteAddr <= addrNext;  // Zero on a miss
    end

endmodule

//--- verification/enemyChecker.sv
// Scoreboard for the chase engine testbench. Samples the DUT on the
// falling edge, compares enemy state after each frame update and the
// renderer outputs one cycle after each probe, and counts mismatches.
module enemyChecker #(
    parameter int NumEnemies = 3
) (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    frameTick,
    input  logic                    updateDone,
    input  logic                    stateCheck,  // Compare state outside an update
    input  logic                    probeValid,
    input  logic [NumEnemies-1:0]   alive,
    input  logic [NumEnemies*9-1:0] enemyXPos,
    input  logic [NumEnemies*9-1:0] enemyYPos,
    input  logic [NumEnemies-1:0]   attackReady,
    input  logic                    isEnemy,
    input  logic [12:0]             spriteAddr,
    input  logic [NumEnemies*9-1:0] expXPos,
    input  logic [NumEnemies*9-1:0] expYPos,
    input  logic [NumEnemies-1:0]   expAtk,
    input  logic                    expHit,
    input  logic [12:0]             expAddr,
    output int                      valueErrors,
    output int                      latencyErrors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic busy;          // Mirrors the chaser, ticks count only when idle
    int   cycles;
    logic probePending;

    initial begin
        valueErrors   = 0;
        latencyErrors = 0;
        busy          = 1'b0;
        cycles        = 0;
        probePending  = 1'b0;
    end

    task automatic compareState(input string what);
        for (int i = 0; i < NumEnemies; i++) begin
            if (enemyXPos[i*9 +: 9] !== expXPos[i*9 +: 9] ||
                enemyYPos[i*9 +: 9] !== expYPos[i*9 +: 9]) begin
                valueErrors++;
                $display("[FAIL] %0t: %s, enemy %0d at (%0d,%0d), expected (%0d,%0d)",
                         $time, what, i, enemyXPos[i*9 +: 9], enemyYPos[i*9 +: 9],
                         expXPos[i*9 +: 9], expYPos[i*9 +: 9]);
            end
        end
        if (attackReady !== expAtk) begin
            valueErrors++;
            $display("[FAIL] %0t: %s, attackReady %b, expected %b",
                     $time, what, attackReady, expAtk);
        end
    endtask

    always @(negedge Clk) begin
        if (!rstN) begin
            busy         = 1'b0;
            probePending = 1'b0;
        end else begin
            if (stateCheck) begin
                compareState("idle state");
                if (updateDone !== 1'b0) begin
                    valueErrors++;
                    $display("[FAIL] %0t: updateDone high with no update running", $time);
                end
            end
            // A dead enemy never shows attackReady, even before its record is rewritten
            if ((attackReady & ~alive) !== '0) begin
                valueErrors++;
                $display("[FAIL] %0t: attackReady %b with alive %b, dead enemies must read 0",
                         $time, attackReady, alive);
            end
            if (busy) begin
                cycles++;
                if (updateDone) begin
                    busy = 1'b0;
                    if (cycles != 2 * NumEnemies + 1) begin
                        latencyErrors++;
                        $display("[FAIL] %0t: updateDone %0d cycles after the tick, expected %0d",
                                 $time, cycles, 2 * NumEnemies + 1);
                    end
                    compareState("frame update");
                end
            end else if (updateDone) begin
                latencyErrors++;
                $display("[FAIL] %0t: updateDone without a frame tick", $time);
            end else if (frameTick) begin
                busy   = 1'b1;
                cycles = 0;
            end
            if (probePending) begin  // Renderer output is one cycle behind the probe
                if (isEnemy !== expHit || spriteAddr !== expAddr) begin
                    valueErrors++;
                    $display("[FAIL] %0t: probe hit %b addr %0d, expected hit %b addr %0d",
                             $time, isEnemy, spriteAddr, expHit, expAddr);
                end
            end
            probePending = probeValid;
        end
    end

endmodule

//--- verification/enemyEngineTb.sv
// Testbench for the chase engine. Reads frame ticks and pixel probes
// from the pattern file, drives them 1 ns after the rising edge and
// leaves all comparing to the checker. Ends with the error counts.
module enemyEngineTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumEnemies = 3;

    logic                    Clk;
    logic                    rstN;
    logic                    frameTick;
    logic [8:0]              playerX;
    logic [8:0]              playerY;
    logic [NumEnemies-1:0]   alive;
    logic [8:0]              pixelX;
    logic [8:0]              pixelY;
    logic                    isEnemy;
    logic [12:0]             spriteAddr;
    logic [NumEnemies-1:0]   attackReady;
    logic [NumEnemies*9-1:0] enemyXPos;
    logic [NumEnemies*9-1:0] enemyYPos;
    logic                    updateDone;

    logic [NumEnemies*9-1:0] expXPos;
    logic [NumEnemies*9-1:0] expYPos;
    logic [NumEnemies-1:0]   expAtk;
    logic                    expHit;
    logic [12:0]             expAddr;
    logic                    stateCheck;
    logic                    probeValid;
    int                      valueErrors;
    int                      latencyErrors;
    int                      badLines = 0;
    string                   patLines[$];
    logic                    loaded = 1'b0;

    enemyEngine #(.NumEnemies(NumEnemies)) uut (
        .Clk(Clk), .rstN(rstN), .frameTick(frameTick), .playerX(playerX),
        .playerY(playerY), .alive(alive), .pixelX(pixelX), .pixelY(pixelY),
        .isEnemy(isEnemy), .spriteAddr(spriteAddr), .attackReady(attackReady),
        .enemyXPos(enemyXPos), .enemyYPos(enemyYPos), .updateDone(updateDone)
    );

    enemyChecker #(.NumEnemies(NumEnemies)) resultCheck (.*);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic loadPatterns();
        int    fd;
        string line;
        fd = $fopen("verification/enemyPatterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            badLines++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line[0] != "#")  // Skip comments and blank lines
                    patLines.push_back(line);
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic probePixel(input int x, input int y, input int hit, input int addr);
        @(posedge Clk);
        #1;
        pixelX     = 9'(x);
        pixelY     = 9'(y);
        expHit     = (hit != 0);
        expAddr    = 13'(addr);
        probeValid = 1'b1;
        @(posedge Clk);
        #1 probeValid = 1'b0;
    endtask

    task automatic applyPattern(input string line);
        string kind;
        int    n;
        int    extra, px, py, al, x0, y0, x1, y1, x2, y2, atk, prx, pry, hit, addr;
        n = $sscanf(line, "%s", kind);
        if (kind == "T") begin
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", kind, extra,
                        px, py, al, x0, y0, x1, y1, x2, y2, atk, prx, pry, hit, addr);
        end else if (kind == "P") begin
            n = $sscanf(line, "%s %d %d %d %d", kind, prx, pry, hit, addr);
        end
        if (kind == "T" && n == 16) begin
            @(posedge Clk);
            #1;
            playerX   = 9'(px);
            playerY   = 9'(py);
            alive     = al[NumEnemies-1:0];
            expXPos   = {9'(x2), 9'(x1), 9'(x0)};
            expYPos   = {9'(y2), 9'(y1), 9'(y0)};
            expAtk    = atk[NumEnemies-1:0];
            frameTick = 1'b1;
            @(posedge Clk);
            #1 frameTick = 1'b0;
            if (extra != 0) begin  // Second tick lands mid-update
                @(posedge Clk);
                #1 frameTick = 1'b1;
                @(posedge Clk);
                #1 frameTick = 1'b0;
            end
            while (!updateDone) begin
                @(posedge Clk);
                #1;
            end
            probePixel(prx, pry, hit, addr);
        end else if (kind == "P" && n == 5) begin
            probePixel(prx, pry, hit, addr);
        end else begin
            $display("Malformed pattern line: %s", line);
            badLines++;
        end
    endtask

    // Watchdog, sized from the pattern count
    initial begin
        wait (loaded);
        repeat (patLines.size() * 20 + 100) @(posedge Clk);
        $display("Timeout: the run did not finish the patterns in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(25845));
        rstN       = 1'b0;
        frameTick  = 1'b0;
        playerX    = '0;
        playerY    = '0;
        alive      = '1;
        pixelX     = '0;
        pixelY     = '0;
        stateCheck = 1'b0;
        probeValid = 1'b0;
        expHit     = 1'b0;
        expAddr    = '0;
        expAtk     = '0;
        for (int i = 0; i < NumEnemies; i++) begin  // Spawn points
            expXPos[i*9 +: 9] = 9'(70 * (i + 1) - 13);
            expYPos[i*9 +: 9] = 9'(40 * (i + 1) - 13);
        end
        loadPatterns();
        repeat (5) @(posedge Clk);
        #1 rstN = 1'b1;
        stateCheck = 1'b1;
        @(posedge Clk);
        #1 stateCheck = 1'b0;
        foreach (patLines[k]) begin
            repeat ($urandom_range(5, 0)) @(posedge Clk);  // Idle gap between lines
            applyPattern(patLines[k]);
        end
        repeat (3) @(posedge Clk);
        $display("Error count: %0d value, %0d latency, %0d pattern file",
                 valueErrors, latencyErrors, badLines);
        if (valueErrors + latencyErrors + badLines == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verification/enemyEngine_assertions.sv
// Concurrent checks on the chaser FSM and the renderer output.
// Bound into both modules. Inputs a module does not have are tied
// off, so those properties hold trivially in that instance.
module enemyEngineAssertions import enemyPkg::*; #(
    parameter int NumEnemies = 3
) (
    input logic        Clk,
    input logic        rstN,
    input chaseStateT  state,
    input logic        wrEn,
    input logic        frameTick,
    input logic        updateDone,
    input logic        isEnemy,
    input logic [12:0] spriteAddr
);
    timeunit 1ns;
    timeprecision 100ps;

    // No table write while waiting for a tick
    idleNoWrite: assert property (@(posedge Clk) disable iff (!rstN)
        state == ChaseIdle |-> !wrEn)
        else $error("Table write strobe while the chaser is idle");

    // Two cycles per enemy, then one more for the done pulse
    doneLatency: assert property (@(posedge Clk) disable iff (!rstN)
        frameTick && state == ChaseIdle |-> ##(2 * NumEnemies + 1) updateDone)
        else $error("updateDone did not follow the accepted frame tick on time");

    addrRange: assert property (@(posedge Clk) disable iff (!rstN)
        isEnemy |-> spriteAddr < 13'd8112)  // 12 frames of 676 pixels
        else $error("Sprite address beyond the last sprite frame");

endmodule

bind enemyChaser enemyEngineAssertions #(.NumEnemies(NumEnemies)) chaserChecks (
    .Clk(Clk), .rstN(rstN), .state(state), .wrEn(tbl.wrEn), .frameTick(frameTick),
    .updateDone(updateDone), .isEnemy(1'b0), .spriteAddr(13'd0)
);

bind spriteRenderer enemyEngineAssertions #(.NumEnemies(NumEnemies)) rendererChecks (
    .Clk(Clk), .rstN(rstN), .state(enemyPkg::ChaseIdle), .wrEn(1'b0), .frameTick(1'b0),
    .updateDone(1'b0), .isEnemy(isEnemy), .spriteAddr(spriteAddr)
);

//--- verification/enemyPatterns.txt
# T extra playerX playerY alive x0 y0 x1 y1 x2 y2 attackReady probeX probeY hit addr
# P probeX probeY hit addr   (all decimal, addr is the expected sprite ROM address)
# Player far right, every enemy steps right
T 0 300 100 7 58 27 128 67 198 107 0 63 30 1 6843
# A second tick during the update is ignored
T 1 300 100 7 59 27 129 67 199 107 0 129 67 1 6084
# Player far left
T 0 10 100 7 58 27 128 67 198 107 0 223 132 1 4055
# Player below, priority picks a different axis per enemy
T 0 128 200 7 59 27 128 68 197 107 0 138 88 1 530
# Player above
T 0 128 0 7 60 27 128 67 196 107 0 128 67 1 4732
# Enemy 0 held at the top bound
T 0 60 0 7 60 27 127 67 195 107 1 61 28 1 4759
# Enemy 1 inside the player window, enemy 0 moves again
T 0 120 70 7 61 27 127 67 194 107 2 196 107 1 3382
# Enemy 1 dead, frozen and not drawn
T 0 120 70 5 62 27 127 67 193 107 0 132 72 0 0
P 127 67 0 0
T 0 120 70 5 63 27 127 67 192 107 0 88 27 1 6109
# Enemy 1 alive again, still inside the player window
T 0 120 70 7 64 27 127 67 191 107 2 130 71 1 2135
P 201 117 1 2298
P 5 200 0 0
